// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int word_w      = 32;
	localparam int reg_addr_w  = 5;
	localparam int dmem_addr_w = 7;
	localparam int imm_w       = 16;
	localparam int op_w        = 6;
	localparam int fn_w        = 6;
	localparam int shamt_w     = 5;
	localparam int target_w    = 26;

	localparam logic [word_w-1:0]     pc_step = 32'd4;
	localparam logic [reg_addr_w-1:0] reg_ra  = 5'd31; // jal link register

	// opcodes
	localparam logic [op_w-1:0] op_special = 6'h00;
	localparam logic [op_w-1:0] op_j       = 6'h02;
	localparam logic [op_w-1:0] op_jal     = 6'h03;
	localparam logic [op_w-1:0] op_beq     = 6'h04;
	localparam logic [op_w-1:0] op_bne     = 6'h05;
	localparam logic [op_w-1:0] op_addi    = 6'h08;
	localparam logic [op_w-1:0] op_lw      = 6'h23;
	localparam logic [op_w-1:0] op_sw      = 6'h2b;

	// function codes under op_special
	localparam logic [fn_w-1:0] fn_sll = 6'h00;
	localparam logic [fn_w-1:0] fn_srl = 6'h02;
	localparam logic [fn_w-1:0] fn_jr  = 6'h08;
	localparam logic [fn_w-1:0] fn_add = 6'h20;
	localparam logic [fn_w-1:0] fn_sub = 6'h22;
	localparam logic [fn_w-1:0] fn_and = 6'h24;
	localparam logic [fn_w-1:0] fn_or  = 6'h25;
	localparam logic [fn_w-1:0] fn_slt = 6'h2a;

	typedef struct packed {
		logic [op_w-1:0]       op;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [shamt_w-1:0]    shamt;
		logic [fn_w-1:0]       funct;
	} r_fields_t;

	typedef struct packed {
		logic [op_w-1:0]       op;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [imm_w-1:0]      imm;
	} i_fields_t;

	// j-type target is raw[target_w-1:0]
	typedef union packed {
		r_fields_t         r;
		i_fields_t         i;
		logic [word_w-1:0] raw;
	} instr_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4,
		alu_sll = 3'd5,
		alu_srl = 3'd6
	} alu_op_e;

	typedef enum logic [2:0] {
		pc_seq       = 3'd0,
		pc_branch_eq = 3'd1,
		pc_branch_ne = 3'd2,
		pc_jump      = 3'd3,
		pc_jump_reg  = 3'd4
	} pc_sel_e;

	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_mem  = 2'd1,
		wb_link = 2'd2
	} wb_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm; // b = sign-extended imm
		logic    reg_we;
		wb_sel_e wb_sel;
		logic    dest_is_rd;  // else rt, link goes to ra
		logic    mem_rd;
		logic    mem_wr;
		pc_sel_e pc_sel;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== design/mips_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
	input  mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t  ctrl
);

	always_comb begin
		// safe default: no write, no memory, fall through
		ctrl.alu_op      = mips_pkg::alu_add;
		ctrl.alu_src_imm = 1'b0;
		ctrl.reg_we      = 1'b0;
		ctrl.wb_sel      = mips_pkg::wb_alu;
		ctrl.dest_is_rd  = 1'b0;
		ctrl.mem_rd      = 1'b0;
		ctrl.mem_wr      = 1'b0;
		ctrl.pc_sel      = mips_pkg::pc_seq;

		if (instr.raw != '0) begin
			case (instr.r.op)
				mips_pkg::op_special: begin
					ctrl.dest_is_rd = 1'b1;
					ctrl.reg_we     = 1'b1;
					case (instr.r.funct)
						mips_pkg::fn_add: ctrl.alu_op = mips_pkg::alu_add;
						mips_pkg::fn_sub: ctrl.alu_op = mips_pkg::alu_sub;
						mips_pkg::fn_and: ctrl.alu_op = mips_pkg::alu_and;
						mips_pkg::fn_or:  ctrl.alu_op = mips_pkg::alu_or;
						mips_pkg::fn_slt: ctrl.alu_op = mips_pkg::alu_slt;
						mips_pkg::fn_sll: ctrl.alu_op = mips_pkg::alu_sll;
						mips_pkg::fn_srl: ctrl.alu_op = mips_pkg::alu_srl;
						mips_pkg::fn_jr: begin
							ctrl.reg_we = 1'b0;
							ctrl.pc_sel = mips_pkg::pc_jump_reg;
						end
						default: ctrl.reg_we = 1'b0; // unknown funct
					endcase
				end
				mips_pkg::op_addi: begin
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_we      = 1'b1;
				end
				mips_pkg::op_lw: begin
					ctrl.alu_src_imm = 1'b1; // address sum
					ctrl.reg_we      = 1'b1;
					ctrl.wb_sel      = mips_pkg::wb_mem;
					ctrl.mem_rd      = 1'b1;
				end
				mips_pkg::op_sw: begin
					ctrl.alu_src_imm = 1'b1;
					ctrl.mem_wr      = 1'b1;
				end
				mips_pkg::op_beq: ctrl.pc_sel = mips_pkg::pc_branch_eq;
				mips_pkg::op_bne: ctrl.pc_sel = mips_pkg::pc_branch_ne;
				mips_pkg::op_j:   ctrl.pc_sel = mips_pkg::pc_jump;
				mips_pkg::op_jal: begin
					ctrl.pc_sel = mips_pkg::pc_jump;
					ctrl.reg_we = 1'b1;
					ctrl.wb_sel = mips_pkg::wb_link;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/mips_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_reg_file (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
	input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
	input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
	input  logic                            wr_en,
	input  logic [mips_pkg::word_w-1:0]     wr_data,
	output logic [mips_pkg::word_w-1:0]     rs_data,
	output logic [mips_pkg::word_w-1:0]     rt_data
);

	logic [mips_pkg::word_w-1:0] regs [2**mips_pkg::reg_addr_w];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin // $zero stays 0
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
	input  mips_pkg::alu_op_e            op,
	input  logic [mips_pkg::word_w-1:0]  a,
	input  logic [mips_pkg::word_w-1:0]  b,
	input  logic [mips_pkg::shamt_w-1:0] shamt,
	output logic [mips_pkg::word_w-1:0]  result
);

	logic [mips_pkg::word_w-1:0] sum;
	logic [mips_pkg::word_w-1:0] diff;
	logic                        less;

	assign sum  = a + b; // wraps
	assign diff = a - b;
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_pkg::alu_add: result = sum;
			mips_pkg::alu_sub: result = diff;
			mips_pkg::alu_and: result = a & b;
			mips_pkg::alu_or:  result = a | b;
			mips_pkg::alu_slt: result = {{(mips_pkg::word_w-1){1'b0}}, less};
			// shifts act on rt, which comes in on b
			mips_pkg::alu_sll: result = b << shamt;
			mips_pkg::alu_srl: result = b >> shamt; // zero fill
			default:           result = sum;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/mips_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit (
	input  logic                             clk,
	input  logic                             rst_n,
	input  mips_pkg::pc_sel_e                pc_sel,
	input  logic [mips_pkg::word_w-1:0]      rs_data,
	input  logic [mips_pkg::word_w-1:0]      rt_data,
	input  logic [mips_pkg::imm_w-1:0]       imm,
	input  logic [mips_pkg::target_w-1:0]    target,
	output logic [mips_pkg::word_w-1:0]      ir_addr
);

	localparam int ext_w = mips_pkg::word_w - mips_pkg::imm_w - 2;
	localparam int top_w = mips_pkg::word_w - mips_pkg::target_w - 2;

	logic [mips_pkg::word_w-1:0] pc_plus4;
	logic [mips_pkg::word_w-1:0] branch_addr;
	logic [mips_pkg::word_w-1:0] jump_addr;
	logic [mips_pkg::word_w-1:0] next_pc;
	logic                        rs_eq_rt;

	assign pc_plus4    = ir_addr + mips_pkg::pc_step;
	assign branch_addr = pc_plus4 + {{ext_w{imm[mips_pkg::imm_w-1]}}, imm, 2'b00};
	assign jump_addr   = {ir_addr[mips_pkg::word_w-1 -: top_w], target, 2'b00};
	assign rs_eq_rt    = rs_data == rt_data;

	always_comb begin
		case (pc_sel)
			mips_pkg::pc_branch_eq: next_pc = rs_eq_rt ? branch_addr : pc_plus4;
			mips_pkg::pc_branch_ne: next_pc = rs_eq_rt ? pc_plus4 : branch_addr;
			mips_pkg::pc_jump:      next_pc = jump_addr;
			mips_pkg::pc_jump_reg:  next_pc = rs_data;
			default:                next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_addr <= '0;
		end else begin
			ir_addr <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [mips_pkg::word_w-1:0]      ir,
	input  logic [mips_pkg::word_w-1:0]      read_data_mem,
	output logic [mips_pkg::word_w-1:0]      ir_addr,
	output logic                             cen,
	output logic                             wen,
	output logic                             oen,
	output logic [mips_pkg::dmem_addr_w-1:0] a,
	output logic [mips_pkg::word_w-1:0]      data_to_mem
);

	localparam int ext_w = mips_pkg::word_w - mips_pkg::imm_w;

	mips_pkg::instr_t instr;
	mips_pkg::ctrl_t  ctrl;

	logic [mips_pkg::word_w-1:0]     rs_data;
	logic [mips_pkg::word_w-1:0]     rt_data;
	logic [mips_pkg::word_w-1:0]     imm_sext;
	logic [mips_pkg::word_w-1:0]     alu_b;
	logic [mips_pkg::word_w-1:0]     alu_result;
	logic [mips_pkg::word_w-1:0]     wr_data;
	logic [mips_pkg::reg_addr_w-1:0] wr_addr;

	assign instr    = ir;
	assign imm_sext = {{ext_w{instr.i.imm[mips_pkg::imm_w-1]}}, instr.i.imm};

	mips_decoder decoder_i (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// destination: ra for jal, rd for r-type, else rt
	always_comb begin
		if (ctrl.wb_sel == mips_pkg::wb_link) begin
			wr_addr = mips_pkg::reg_ra;
		end else if (ctrl.dest_is_rd) begin
			wr_addr = instr.r.rd;
		end else begin
			wr_addr = instr.i.rt;
		end
	end

	always_comb begin
		case (ctrl.wb_sel)
			mips_pkg::wb_mem:  wr_data = read_data_mem;
			mips_pkg::wb_link: wr_data = ir_addr + mips_pkg::pc_step;
			default:           wr_data = alu_result;
		endcase
	end

	mips_reg_file reg_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (instr.r.rs),
		.rt_addr (instr.r.rt),
		.wr_addr (wr_addr),
		.wr_en   (ctrl.reg_we),
		.wr_data (wr_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	assign alu_b = ctrl.alu_src_imm ? imm_sext : rt_data;

	mips_alu alu_i (
		.op     (ctrl.alu_op),
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (instr.r.shamt),
		.result (alu_result)
	);

	mips_pc_unit pc_unit_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.pc_sel  (ctrl.pc_sel),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.imm     (instr.i.imm),
		.target  (instr.raw[mips_pkg::target_w-1:0]),
		.ir_addr (ir_addr)
	);

	// memory strobes, all active low
	assign cen = ~(ctrl.mem_rd | ctrl.mem_wr);
	assign wen = ~ctrl.mem_wr;
	assign oen = ~ctrl.mem_rd;

	assign a           = alu_result[mips_pkg::dmem_addr_w+1:2]; // byte to word address
	assign data_to_mem = rt_data;

endmodule

`default_nettype wire

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

	logic        clk;
	logic        rst_n;
	logic [31:0] ir;
	logic [31:0] read_data_mem;
	logic [31:0] ir_addr;
	logic        cen;
	logic        wen;
	logic        oen;
	logic [6:0]  a;
	logic [31:0] data_to_mem;

	logic [31:0] rom [0:63];
	logic [31:0] ram [0:127];
	logic [15:0] lfsr;
	int          value_errors;
	int          other_errors;

	// reference model state
	logic [31:0] m_pc;
	logic [31:0] m_reg [0:31];
	logic [31:0] m_mem [0:127];
	logic [31:0] m_ir;
	logic [31:0] m_rs;
	logic [31:0] m_rt;
	logic [31:0] m_sext;
	logic [31:0] m_next_pc;
	logic        m_wr_en;
	logic [4:0]  m_wr_idx;
	logic [31:0] m_wr_val;
	logic        exp_cen;
	logic        exp_wen;
	logic        exp_oen;
	logic [6:0]  exp_a;

	mips_core mips_core_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.ir            (ir),
		.read_data_mem (read_data_mem),
		.ir_addr       (ir_addr),
		.cen           (cen),
		.wen           (wen),
		.oen           (oen),
		.a             (a),
		.data_to_mem   (data_to_mem)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// memories answer in zero wait states
	assign ir            = rom[ir_addr[7:2]];
	assign read_data_mem = ram[a];

	always @(posedge clk) begin
		if (!cen && !wen) ram[a] <= data_to_mem;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] enc_r(input int rs, rt, rd, sh, input logic [5:0] fn);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, rt,
			input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	// model decode, straight from the instruction set rules
	always_comb begin
		m_ir      = rom[m_pc[7:2]];
		m_rs      = m_reg[m_ir[25:21]];
		m_rt      = m_reg[m_ir[20:16]];
		m_sext    = {{16{m_ir[15]}}, m_ir[15:0]};
		m_next_pc = m_pc + 32'd4;
		m_wr_en   = 1'b0;
		m_wr_idx  = m_ir[20:16];
		m_wr_val  = '0;
		exp_cen   = 1'b1;
		exp_wen   = 1'b1;
		exp_oen   = 1'b1;
		exp_a     = 7'((m_rs + m_sext) >> 2);
		case (m_ir[31:26])
			mips_pkg::op_special: begin
				m_wr_en  = m_ir != '0;
				m_wr_idx = m_ir[15:11];
				case (m_ir[5:0])
					mips_pkg::fn_add: m_wr_val = m_rs + m_rt;
					mips_pkg::fn_sub: m_wr_val = m_rs - m_rt;
					mips_pkg::fn_and: m_wr_val = m_rs & m_rt;
					mips_pkg::fn_or:  m_wr_val = m_rs | m_rt;
					mips_pkg::fn_slt: m_wr_val = {31'd0, $signed(m_rs) < $signed(m_rt)};
					mips_pkg::fn_sll: m_wr_val = m_rt << m_ir[10:6];
					mips_pkg::fn_srl: m_wr_val = m_rt >> m_ir[10:6];
					mips_pkg::fn_jr: begin
						m_wr_en   = 1'b0;
						m_next_pc = m_rs;
					end
					default: m_wr_en = 1'b0;
				endcase
			end
			mips_pkg::op_addi: begin
				m_wr_en  = 1'b1;
				m_wr_val = m_rs + m_sext;
			end
			mips_pkg::op_lw: begin
				m_wr_en  = 1'b1;
				m_wr_val = m_mem[exp_a];
				exp_cen  = 1'b0;
				exp_oen  = 1'b0;
			end
			mips_pkg::op_sw: begin
				exp_cen = 1'b0;
				exp_wen = 1'b0;
			end
			mips_pkg::op_beq: if (m_rs == m_rt) m_next_pc = m_pc + 32'd4 + (m_sext << 2);
			mips_pkg::op_bne: if (m_rs != m_rt) m_next_pc = m_pc + 32'd4 + (m_sext << 2);
			mips_pkg::op_j:   m_next_pc = {m_pc[31:28], m_ir[25:0], 2'b00};
			mips_pkg::op_jal: begin
				m_next_pc = {m_pc[31:28], m_ir[25:0], 2'b00};
				m_wr_en   = 1'b1;
				m_wr_idx  = 5'd31;
				m_wr_val  = m_pc + 32'd4;
			end
			default: ;
		endcase
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_pc <= '0;
			for (int i = 0; i < 32; i++) m_reg[i] <= '0;
		end else begin
			m_pc <= m_next_pc;
			if (m_wr_en && m_wr_idx != 5'd0) m_reg[m_wr_idx] <= m_wr_val;
			if (!exp_cen && !exp_wen) m_mem[exp_a] <= m_rt;
		end
	end

	reset_state: assert property (@(posedge clk) !rst_n |-> (ir_addr == '0 && cen && wen && oen))
		else begin
			other_errors++;
			$display("%0t: outputs not at reset values while rst_n is low", $time);
		end

	pc_follows: assert property (@(posedge clk) disable iff (!rst_n) ir_addr == m_pc)
		else begin
			value_errors++;
			$display("[ERROR] %0t ir_addr expected %h got %h", $time, $sampled(m_pc),
				$sampled(ir_addr));
		end

	strobes_match: assert property (@(posedge clk) disable iff (!rst_n)
			{cen, wen, oen} == {exp_cen, exp_wen, exp_oen})
		else begin
			value_errors++;
			$display("[ERROR] %0t cen/wen/oen expected %b got %b", $time,
				$sampled({exp_cen, exp_wen, exp_oen}), $sampled({cen, wen, oen}));
		end

	addr_match: assert property (@(posedge clk) disable iff (!rst_n) !exp_cen |-> a == exp_a)
		else begin
			value_errors++;
			$display("[ERROR] %0t a expected %h got %h", $time, $sampled(exp_a), $sampled(a));
		end

	store_data: assert property (@(posedge clk) disable iff (!rst_n)
			!exp_wen |-> data_to_mem == m_rt)
		else begin
			value_errors++;
			$display("[ERROR] %0t data_to_mem expected %h got %h", $time, $sampled(m_rt),
				$sampled(data_to_mem));
		end

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] sh;
		logic [5:0]  fns [0:6];
		int          cycles;

		rst_n         = 1'b0;
		value_errors  = 0;
		other_errors  = 0;
		lfsr          = 16'd45;
		fns           = '{mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and,
			mips_pkg::fn_or, mips_pkg::fn_slt, mips_pkg::fn_sll, mips_pkg::fn_srl};
		for (int i = 0; i < 128; i++) begin
			ram[i]   = 32'h5a00_0000 ^ (i * 32'h0101_0103);
			m_mem[i] = ram[i];
		end
		for (int i = 0; i < 64; i++) rom[i] = '0; // nop
		take_bits(16, r1);
		take_bits(16, r2);
		rom[0] = enc_i(mips_pkg::op_addi, 0, 1, r1[15:0]);
		rom[1] = enc_i(mips_pkg::op_addi, 0, 2, r2[15:0]);
		for (int k = 0; k < 7; k++) begin
			take_bits(5, sh);
			rom[2+2*k] = enc_r(1, 2, 3, sh, fns[k]);
			rom[3+2*k] = enc_i(mips_pkg::op_sw, 0, 3, 16'(4*k));
		end
		rom[16] = enc_i(mips_pkg::op_sw, 0, 1, 16'd40);
		rom[17] = enc_i(mips_pkg::op_lw, 0, 4, 16'd40);
		rom[18] = enc_i(mips_pkg::op_sw, 0, 4, 16'd44);
		rom[19] = enc_i(mips_pkg::op_addi, 0, 0, r2[15:0] | 16'h0001); // lost in $zero
		rom[20] = enc_i(mips_pkg::op_sw, 0, 0, 16'd48);
		rom[21] = enc_i(mips_pkg::op_beq, 1, 1, 16'd1);      // taken
		rom[22] = enc_i(mips_pkg::op_addi, 0, 5, 16'd1);
		rom[23] = enc_i(mips_pkg::op_beq, 1, 2, 16'd1);
		rom[24] = enc_i(mips_pkg::op_bne, 1, 2, 16'd1);
		rom[26] = enc_i(mips_pkg::op_bne, 1, 1, 16'd1);      // not taken
		rom[27] = {mips_pkg::op_j, 26'd29};
		rom[29] = {mips_pkg::op_jal, 26'd32};
		rom[30] = enc_i(mips_pkg::op_sw, 0, 31, 16'd52);
		rom[31] = {mips_pkg::op_j, 26'd31};                  // park here
		rom[32] = enc_r(31, 0, 0, 0, mips_pkg::fn_jr);

		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		cycles = 0;
		while (ir_addr != 32'd124 && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= 200) begin
			$display("timeout: the program never reached its final loop");
			$display("Test failed");
			$finish;
		end
		repeat (4) @(negedge clk);

		if (ram[11] !== ram[10]) begin
			other_errors++;
			$display("reloaded word differs from the stored original");
		end
		if (ram[13] !== 32'd120) begin
			other_errors++;
			$display("jal link address was not stored as expected");
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_reg_file.sv
design/mips_alu.sv
design/mips_pc_unit.sv
design/mips_core.sv
sim/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall --top-module tb_mips_core \
	-f flist.f -o tb_mips_core_sim > build.log 2>&1

./obj_dir/tb_mips_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
